// ==== Bender.yml ====
package:
  name: ball_link

sources:
  - include_dirs:
      - logic
    files:
      - logic/ball_pkg.sv
      - logic/i2c_pkg.sv
      - logic/i2c_byte_master.sv
      - logic/ball_frame_sender.sv
      - logic/ball_link_top.sv
      - target: simulation
        files:
          - sim/i2c_target_model.sv
          - sim/ball_link_tb.sv

// ==== logic/ball_frame_sender.sv ====
`default_nettype none
`include "i2c_macros.svh"

module ball_frame_sender (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   send_trigger,
    input  wire ball_pkg::ball_state_t ball,
    input  wire i2c_pkg::i2c_rsp_t     rsp,
    output i2c_pkg::i2c_cmd_t     cmd,
    output i2c_pkg::link_status_t status,
    output logic [7:0]            state_led
);
    import ball_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_WAIT,
        ST_SEND_ADDR,
        ST_SEND_DATA,
        ST_STOP,
        ST_DONE
    } state_t;

    // which operation the wait state is waiting on
    typedef enum logic [1:0] {
        PH_START,
        PH_ADDR,
        PH_DATA,
        PH_STOP
    } phase_t;

    localparam frame_byte_idx_t LAST_IDX = frame_byte_idx_t'(`FRAME_DATA_BYTES - 1);

    state_t          state, state_next;
    phase_t          phase, phase_next;
    frame_byte_idx_t idx, idx_next;
    logic            nack_seen, nack_seen_next;
    ball_state_t     snap;

    function automatic logic [7:0] frame_byte(input ball_state_t b, input frame_byte_idx_t i);
        case (i)
            3'd0: frame_byte = {b.ball_y[9:8], 6'b0};
            3'd1: frame_byte = b.ball_y[7:0];
            3'd2: frame_byte = b.ball_vy;
            3'd3: frame_byte = {6'b0, b.gravity};
            3'd4: frame_byte = {7'b0, b.collision};
            default: frame_byte = {7'b0, b.lose};
        endcase
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= ST_IDLE;
            phase     <= PH_START;
            idx       <= '0;
            nack_seen <= 1'b0;
        end else begin
            state     <= state_next;
            phase     <= phase_next;
            idx       <= idx_next;
            nack_seen <= nack_seen_next;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && send_trigger) begin
            snap <= ball;
        end
    end

    always_comb begin
        state_next     = state;
        phase_next     = phase;
        idx_next       = idx;
        nack_seen_next = nack_seen;
        cmd.start      = 1'b0;
        cmd.stop       = 1'b0;
        cmd.enable     = 1'b0;
        cmd.data       = `I2C_TARGET_ADDR;
        state_led      = 8'h01;
        case (state)
            ST_IDLE: begin
                if (send_trigger) begin
                    state_next     = ST_START;
                    idx_next       = '0;
                    nack_seen_next = 1'b0;
                end
            end
            ST_START: begin
                state_led  = 8'h02;
                cmd.start  = 1'b1;
                cmd.enable = 1'b1;
                if (!rsp.ready) begin
                    state_next = ST_WAIT;
                    phase_next = PH_START;
                end
            end
            ST_WAIT: begin
                state_led = 8'h04;
                if (rsp.ready) begin
                    case (phase)
                        PH_START: state_next = ST_SEND_ADDR;
                        PH_STOP:  state_next = ST_DONE;
                        default: begin
                            if (rsp.nack) begin    // abort rest of frame
                                nack_seen_next = 1'b1;
                                state_next     = ST_STOP;
                            end else if (phase == PH_ADDR) begin
                                state_next = ST_SEND_DATA;
                            end else if (idx == LAST_IDX) begin
                                state_next = ST_STOP;
                            end else begin
                                idx_next   = idx + 3'd1;
                                state_next = ST_SEND_DATA;
                            end
                        end
                    endcase
                end
            end
            ST_SEND_ADDR: begin
                state_led  = 8'h08;
                cmd.enable = 1'b1;
                if (!rsp.ready) begin
                    state_next = ST_WAIT;
                    phase_next = PH_ADDR;
                end
            end
            ST_SEND_DATA: begin
                state_led  = 8'h10;
                cmd.enable = 1'b1;
                cmd.data   = frame_byte(snap, idx);
                if (!rsp.ready) begin
                    state_next = ST_WAIT;
                    phase_next = PH_DATA;
                end
            end
            ST_STOP: begin
                state_led  = 8'h20;
                cmd.stop   = 1'b1;
                cmd.enable = 1'b1;
                if (!rsp.ready) begin
                    state_next = ST_WAIT;
                    phase_next = PH_STOP;
                end
            end
            ST_DONE: begin
                state_led  = 8'h40;
                state_next = ST_IDLE;
            end
            default: state_next = ST_IDLE;
        endcase
    end

    // done pulses in the one cycle busy is already low
    always_comb begin
        status.busy      = (state != ST_IDLE) && (state != ST_DONE);
        status.done_ok   = (state == ST_DONE) && !nack_seen;
        status.done_nack = (state == ST_DONE) && nack_seen;
    end

endmodule

`default_nettype wire

// ==== logic/ball_link_top.sv ====
`default_nettype none

module ball_link_top (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        send_trigger,
    input  wire ball_pkg::ball_state_t ball,
    output i2c_pkg::link_status_t      status,
    output logic [7:0]                 state_led,
    output logic                       scl,
    output logic                       sda_low,
    input  wire                        sda_in
);
    import i2c_pkg::*;

    i2c_cmd_t cmd;
    i2c_rsp_t rsp;

    ball_frame_sender u_sender (
        .clk          (clk),
        .reset        (reset),
        .send_trigger (send_trigger),
        .ball         (ball),
        .rsp          (rsp),
        .cmd          (cmd),
        .status       (status),
        .state_led    (state_led)
    );

    i2c_byte_master u_master (
        .clk     (clk),
        .reset   (reset),
        .cmd     (cmd),
        .rsp     (rsp),
        .scl     (scl),
        .sda_low (sda_low),
        .sda_in  (sda_in)
    );

endmodule

`default_nettype wire

// ==== logic/ball_pkg.sv ====
`default_nettype none

package ball_pkg;

    // one snapshot of the ball as seen by the game logic
    typedef struct packed {
        logic [9:0] ball_y;
        logic [7:0] ball_vy;
        logic [1:0] gravity;    // gravity phase
        logic       collision;
        logic       lose;
    } ball_state_t;

    // position of a data byte within a frame
    typedef logic [2:0] frame_byte_idx_t;

endpackage

`default_nettype wire

// ==== logic/i2c_byte_master.sv ====
`default_nettype none
`include "i2c_macros.svh"

module i2c_byte_master (
    input  wire                    clk,
    input  wire                    reset,
    input  wire i2c_pkg::i2c_cmd_t cmd,
    output i2c_pkg::i2c_rsp_t      rsp,
    output logic                   scl,       // 1 pulls SCL low
    output logic                   sda_low,   // 1 pulls SDA low
    input  wire                    sda_in
);

    localparam int TICK_W = $clog2(`I2C_HALF_PERIOD);
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`I2C_HALF_PERIOD - 1);

    // byte = 9 bits, each a low half then a high half
    localparam logic [4:0] DATA_LAST_HALF = 5'd15;
    localparam logic [4:0] BYTE_LAST_HALF = 5'd17;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_BYTE,
        ST_STOP
    } state_t;

    state_t            state;
    logic [TICK_W-1:0] tick;
    logic [4:0]        half;
    logic [7:0]        shift;
    logic              nack_r;
    logic              half_end;

    assign half_end = (tick == TICK_LAST);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= ST_IDLE;
            tick    <= '0;
            half    <= '0;
            nack_r  <= 1'b0;
            scl     <= 1'b0;
            sda_low <= 1'b0;
        end else begin
            if (state != ST_IDLE) begin
                tick <= half_end ? '0 : tick + 1'b1;
            end
            case (state)
                ST_IDLE: begin
                    tick <= '0;
                    half <= '0;
                    if (cmd.enable) begin
                        if (cmd.start) begin
                            // SDA falls while SCL is still high
                            state   <= ST_START;
                            scl     <= 1'b0;
                            sda_low <= 1'b1;
                        end else if (cmd.stop) begin
                            state   <= ST_STOP;
                            scl     <= 1'b1;
                            sda_low <= 1'b1;
                        end else begin
                            state   <= ST_BYTE;
                            nack_r  <= 1'b0;
                            scl     <= 1'b1;
                            sda_low <= ~cmd.data[7];   // msb first
                        end
                    end
                end
                ST_START: begin
                    if (half_end) begin
                        if (!half[0]) begin
                            half <= 5'd1;
                            scl  <= 1'b1;
                        end else begin
                            state <= ST_IDLE;   // hold SCL low, SDA low
                        end
                    end
                end
                ST_BYTE: begin
                    if (half_end) begin
                        half <= half + 5'd1;
                        if (!half[0]) begin
                            scl <= 1'b0;   // rising SCL edge
                        end else if (half == BYTE_LAST_HALF) begin
                            state  <= ST_IDLE;
                            scl    <= 1'b1;
                            nack_r <= sda_in;   // ack bit, SCL high
                        end else begin
                            scl     <= 1'b1;
                            sda_low <= (half == DATA_LAST_HALF) ? 1'b0 : ~shift[6];
                        end
                    end
                end
                ST_STOP: begin
                    if (half_end) begin
                        if (!half[0]) begin
                            half <= 5'd1;
                            scl  <= 1'b0;
                        end else begin
                            // SDA rises while SCL high
                            state   <= ST_IDLE;
                            sda_low <= 1'b0;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && cmd.enable) begin
            shift <= cmd.data;
        end else if (state == ST_BYTE && half_end && half[0]) begin
            shift <= shift << 1;
        end
    end

    always_comb begin
        rsp.ready = (state == ST_IDLE);
        rsp.nack  = nack_r;
    end

endmodule

`default_nettype wire

// ==== logic/i2c_macros.svh ====
`ifndef I2C_MACROS_SVH
`define I2C_MACROS_SVH

// system clocks per half SCL period, 2 or more
`define I2C_HALF_PERIOD 4

// target address with write bit
`define I2C_TARGET_ADDR 8'hAA

// data bytes after the address byte
`define FRAME_DATA_BYTES 6

`endif

// ==== logic/i2c_pkg.sv ====
`default_nettype none

package i2c_pkg;

    // sender -> byte master, held until ready drops
    typedef struct packed {
        logic       start;
        logic       stop;
        logic       enable;
        logic [7:0] data;
    } i2c_cmd_t;

    typedef struct packed {
        logic ready;
        logic nack;     // valid with ready after a byte
    } i2c_rsp_t;

    typedef struct packed {
        logic busy;
        logic done_ok;
        logic done_nack;
    } link_status_t;

endpackage

`default_nettype wire

// ==== project.f ====
+incdir+logic
logic/ball_pkg.sv
logic/i2c_pkg.sv
logic/i2c_byte_master.sv
logic/ball_frame_sender.sv
logic/ball_link_top.sv
sim/i2c_target_model.sv
sim/ball_link_tb.sv

// ==== sim/ball_link_tb.sv ====
`default_nettype none
`include "i2c_macros.svh"

module ball_link_tb;
    import ball_pkg::*;
    import i2c_pkg::*;

    // rough cycle cost of each bus operation including the handshake
    localparam int OP_CYCLES     = 2 * `I2C_HALF_PERIOD + 4;
    localparam int BYTE_CYCLES   = 18 * `I2C_HALF_PERIOD + 4;
    localparam int FRAME_CYCLES  = 2 * OP_CYCLES + (`FRAME_DATA_BYTES + 1) * BYTE_CYCLES;
    localparam int TIMEOUT_CYCLES = 6 * FRAME_CYCLES;   // per test

    // {busy, done_ok, done_nack}
    localparam link_status_t IDLE_STATUS = 3'b000;
    localparam link_status_t BUSY_STATUS = 3'b100;
    localparam link_status_t OK_STATUS   = 3'b010;
    localparam link_status_t NACK_STATUS = 3'b001;

    logic         clk;
    logic         reset;
    logic         send_trigger;
    ball_state_t  ball;
    link_status_t status;
    logic [7:0]   state_led;
    logic         scl;
    logic         sda_low;
    logic         nack_addr;
    logic         model_pull;
    wire          scl_line;
    wire          sda_line;

    int seed = 36;
    int test_id;
    int seen_id;
    int cycles;
    int stops_expected;

    assign scl_line = !scl;
    assign sda_line = !(sda_low || model_pull);   // pulled up unless someone drives low

    ball_link_top UUT (
        .clk          (clk),
        .reset        (reset),
        .send_trigger (send_trigger),
        .ball         (ball),
        .status       (status),
        .state_led    (state_led),
        .scl          (scl),
        .sda_low      (sda_low),
        .sda_in       (sda_line)
    );

    i2c_target_model target (
        .clk       (clk),
        .reset     (reset),
        .scl_line  (scl_line),
        .sda_line  (sda_line),
        .nack_addr (nack_addr),
        .sda_pull  (model_pull)
    );

    always #5 clk = ~clk;

    // watchdog restarts with every test
    always @(posedge clk) begin
        if (test_id != seen_id) begin
            seen_id = test_id;
            cycles  = 0;
        end else begin
            cycles = cycles + 1;
        end
        if (cycles > TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout after %0d cycles in test %0d", cycles, test_id));
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("Mismatch in %s: expected %h, actual %h",
                                name, expected, actual));
        end
    endtask

    task automatic check_status(input string name, input link_status_t expected,
                                input link_status_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("Mismatch in %s status: expected %b, actual %b",
                                name, expected, actual));
        end
    endtask

    task automatic check_led(input string name, input logic [7:0] expected,
                             input logic [7:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("Mismatch in %s state_led: expected %h, actual %h",
                                name, expected, actual));
        end
    endtask

    task automatic pulse_trigger(input ball_state_t b);
        @(posedge clk);
        send_trigger <= 1'b1;
        ball         <= b;
        @(posedge clk);
        send_trigger <= 1'b0;
    endtask

    task automatic send_frame(input string name, input ball_state_t b);
        pulse_trigger(b);
        @(negedge clk);
        check_status(name, BUSY_STATUS, status);   // busy one cycle after trigger
    endtask

    task automatic wait_frame_end(input string name, input logic nack);
        @(negedge clk);
        while (!(status.done_ok || status.done_nack)) begin
            @(negedge clk);
        end
        check_status(name, nack ? NACK_STATUS : OK_STATUS, status);
        check_led(name, 8'h40, state_led);
        @(negedge clk);
        check_status(name, IDLE_STATUS, status);   // done is a single pulse
        check_led(name, 8'h01, state_led);
    endtask

    task automatic expect_stop(input string name);
        if (target.stop_count != stops_expected + 1) begin
            abort_run($sformatf("%s: no STOP condition seen at the end of the frame", name));
        end
        stops_expected = stops_expected + 1;
    endtask

    task automatic expect_frame(input string name, input ball_state_t b);
        if (target.rx_q.size() != `FRAME_DATA_BYTES + 1) begin
            abort_run($sformatf("%s: %0d bytes arrived, a frame has %0d",
                                name, target.rx_q.size(), `FRAME_DATA_BYTES + 1));
        end
        check_byte(name, `I2C_TARGET_ADDR, target.rx_q[0]);
        check_byte(name, {b.ball_y[9:8], 6'b0}, target.rx_q[1]);
        check_byte(name, b.ball_y[7:0], target.rx_q[2]);
        check_byte(name, b.ball_vy, target.rx_q[3]);
        check_byte(name, {6'b0, b.gravity}, target.rx_q[4]);
        check_byte(name, {7'b0, b.collision}, target.rx_q[5]);
        check_byte(name, {7'b0, b.lose}, target.rx_q[6]);
        target.rx_q.delete();
        expect_stop(name);
    endtask

    task automatic idle_after_reset();
        test_id = test_id + 1;
        check_status("reset", IDLE_STATUS, status);
        check_led("reset", 8'h01, state_led);
        repeat (20) begin
            @(negedge clk);
            if (!scl_line || !sda_line) begin
                abort_run("reset: a bus line was pulled low while the link was idle");
            end
        end
    endtask

    task automatic one_fixed_frame();
        ball_state_t b;
        test_id = test_id + 1;
        b = {10'h2C5, 8'hF3, 2'b10, 1'b1, 1'b0};   // y, vy, gravity, collision, lose
        send_frame("fixed frame", b);
        wait_frame_end("fixed frame", 1'b0);
        expect_frame("fixed frame", b);
    endtask

    task automatic extreme_y_frames();
        ball_state_t b;
        test_id = test_id + 1;
        b = {10'h3FF, 8'h80, 2'b11, 1'b0, 1'b1};
        send_frame("y 0x3ff", b);
        wait_frame_end("y 0x3ff", 1'b0);
        expect_frame("y 0x3ff", b);
        b = {10'h100, 8'h01, 2'b01, 1'b1, 1'b1};
        send_frame("y 0x100", b);
        wait_frame_end("y 0x100", 1'b0);
        expect_frame("y 0x100", b);
    endtask

    task automatic trigger_while_busy();
        ball_state_t first;
        ball_state_t second;
        test_id = test_id + 1;
        first  = {10'h0A5, 8'h3C, 2'b01, 1'b0, 1'b0};
        second = {10'h35A, 8'hC3, 2'b10, 1'b1, 1'b1};
        send_frame("busy trigger", first);
        repeat (30) @(posedge clk);
        pulse_trigger(second);   // ignored and not queued
        wait_frame_end("busy trigger", 1'b0);
        expect_frame("busy trigger", first);
        repeat (FRAME_CYCLES) begin
            @(negedge clk);
            check_status("busy trigger idle", IDLE_STATUS, status);
        end
        if (target.rx_q.size() != 0) begin
            abort_run("busy trigger: a second frame was sent after the first");
        end
    endtask

    task automatic nack_on_address();
        ball_state_t b;
        test_id = test_id + 1;
        b = {10'h1E1, 8'h55, 2'b00, 1'b1, 1'b0};
        @(posedge clk);
        nack_addr <= 1'b1;
        send_frame("address nack", b);
        wait_frame_end("address nack", 1'b1);
        if (target.rx_q.size() != 1) begin
            abort_run($sformatf("address nack: %0d bytes arrived, only the address expected",
                                target.rx_q.size()));
        end
        check_byte("address nack", `I2C_TARGET_ADDR, target.rx_q[0]);
        target.rx_q.delete();
        expect_stop("address nack");
        @(posedge clk);
        nack_addr <= 1'b0;
    endtask

    task automatic random_back_to_back();
        ball_state_t b;
        logic [31:0] r;
        string       name;
        test_id = test_id + 1;
        for (int i = 0; i < 4; i++) begin
            r    = $random(seed);
            b    = r[21:0];
            name = $sformatf("random frame %0d", i);
            send_frame(name, b);
            wait_frame_end(name, 1'b0);
            expect_frame(name, b);
        end
    endtask

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        send_trigger   = 1'b0;
        ball           = '0;
        nack_addr      = 1'b0;
        test_id        = 0;
        seen_id        = 0;
        cycles         = 0;
        stops_expected = 0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        idle_after_reset();
        one_fixed_frame();
        extreme_y_frames();
        trigger_while_busy();
        nack_on_address();
        random_back_to_back();
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/i2c_target_model.sv ====
`default_nettype none

module i2c_target_model (
    input  wire  clk,
    input  wire  reset,
    input  wire  scl_line,
    input  wire  sda_line,
    input  wire  nack_addr,   // leave the address byte unacknowledged
    output logic sda_pull     // 1 pulls SDA low
);

    logic [7:0] rx_q[$];      // every byte seen on the bus, address included
    int         stop_count;

    logic       scl_prev;
    logic       sda_prev;
    logic       active;       // between START and STOP
    logic       first_byte;
    logic [3:0] bit_cnt;
    logic [7:0] shift;

    // lines sampled mid-cycle, away from the master's update edge
    always @(negedge clk or posedge reset) begin
        if (reset) begin
            scl_prev   <= 1'b1;
            sda_prev   <= 1'b1;
            active     <= 1'b0;
            first_byte <= 1'b0;
            bit_cnt    <= '0;
            shift      <= '0;
            sda_pull   <= 1'b0;
            stop_count <= 0;
        end else begin
            scl_prev <= scl_line;
            sda_prev <= sda_line;
            if (scl_prev && scl_line && sda_prev && !sda_line) begin
                active     <= 1'b1;   // start
                first_byte <= 1'b1;
                bit_cnt    <= '0;
            end else if (scl_prev && scl_line && !sda_prev && sda_line) begin
                active     <= 1'b0;   // stop
                sda_pull   <= 1'b0;
                stop_count <= stop_count + 1;
            end else if (active && !scl_prev && scl_line) begin
                if (bit_cnt < 4'd8) begin
                    shift <= {shift[6:0], sda_line};   // msb first
                end
                bit_cnt <= bit_cnt + 4'd1;
            end else if (active && scl_prev && !scl_line) begin
                if (bit_cnt == 4'd8) begin
                    // byte complete, ack during the ninth clock
                    rx_q.push_back(shift);
                    sda_pull   <= !(first_byte && nack_addr);
                    first_byte <= 1'b0;
                end else if (bit_cnt == 4'd9) begin
                    sda_pull <= 1'b0;
                    bit_cnt  <= '0;
                end
            end
        end
    end

endmodule

`default_nettype wire
